// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_soc_harness
FILELIST := soc_harness.f
OBJ_DIR  := obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/soc_harness_checker.sv ====
`timescale 1ns/1ps

module soc_harness_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic sys_rst_ni,
  input logic req_i,
  input logic rvalid_i,
  input logic err_i
);

  // every response belongs to a request one cycle earlier
  a_rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> $past(req_i))
    else $error("rvalid_o without a request in the previous cycle");

  // error flag only travels with a response
  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |-> rvalid_i)
    else $error("err_o high without rvalid_o");

  // no responses while the system is held in reset
  a_quiet_in_reset: assert property (@(posedge clk_i)
    !sys_rst_ni |-> !rvalid_i)
    else $error("rvalid_o high while sys_rst_no is low");

endmodule

bind soc_harness soc_harness_checker i_checker (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .sys_rst_ni ( sys_rst_no ),
  .req_i      ( req_i      ),
  .rvalid_i   ( rvalid_o   ),
  .err_i      ( err_o      )
);

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned ClkPeriod   = 40,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(ClkPeriod / 2);
      clk_o = ~clk_o;
    end
  end

  // release on the falling edge away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== sim/tb_soc_harness.sv ====
`timescale 1ns/1ps

module tb_soc_harness;
  import harness_bus_pkg::*;
  import harness_cfg_pkg::*;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned SramWords = DefaultSramWords;
  localparam int unsigned DbgDelay  = 20;
  localparam int unsigned NumRandom = 200;
  // cycles of all tests together with reset and flush cycles
  localparam int unsigned TotalCycles = 4 + DbgDelay + 16 + SramWords + NumRandom + 32 + 40 + 30;

  logic        clk;
  logic        rst_n;
  logic        ndmreset;
  logic        jtag_sel;
  logic        jtag_req;
  logic        dtm_req;
  logic        req;
  logic        we;
  addr_t       addr;
  strb_t       be;
  data_t       wdata;
  data_t       rdata;
  logic        rvalid;
  logic        err;
  logic        dbg_req;
  logic        sys_rst_n;

  // reference model state
  data_t       model_mem [SramWords];
  logic        sys_up;
  logic        exp_valid;
  logic        exp_err;
  logic        exp_chk;
  data_t       exp_rdata;
  int unsigned checks;
  int unsigned errors;
  int unsigned test_errors;
  int unsigned tests;
  int unsigned failed;
  logic [3:0]  region;
  logic [27:0] offset;
  addr_t       fill_addr;

  tb_clk_gen #(
    .ClkPeriod   ( ClkPeriod ),
    .ResetCycles ( 3         )
  ) i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_harness #(
    .NumWords   ( SramWords ),
    .DebugDelay ( DbgDelay  )
  ) DUT (
    .clk_i      ( clk       ),
    .rst_ni     ( rst_n     ),
    .ndmreset_i ( ndmreset  ),
    .jtag_sel_i ( jtag_sel  ),
    .jtag_req_i ( jtag_req  ),
    .dtm_req_i  ( dtm_req   ),
    .req_i      ( req       ),
    .we_i       ( we        ),
    .addr_i     ( addr      ),
    .be_i       ( be        ),
    .wdata_i    ( wdata     ),
    .rdata_o    ( rdata     ),
    .rvalid_o   ( rvalid    ),
    .err_o      ( err       ),
    .dbg_req_o  ( dbg_req   ),
    .sys_rst_no ( sys_rst_n )
  );

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_response();
    check_value("rvalid_o", 64'(rvalid), 64'(exp_valid));
    check_value("err_o", 64'(err), 64'(exp_err));
    if (exp_chk) begin
      check_value("rdata_o", rdata, exp_rdata);
    end
  endtask

  // predicts the response due one cycle later from the address map rules
  task automatic predict(input logic r, input logic w, input addr_t a, input strb_t b,
                         input data_t d);
    int unsigned idx;
    idx       = (a >> 3) % SramWords;
    exp_valid = r && sys_up;
    exp_err   = 1'b0;
    exp_chk   = 1'b0;
    exp_rdata = '0;
    if (exp_valid) begin
      if (a[31:28] == RegionDram) begin
        exp_chk   = !w;
        exp_rdata = model_mem[idx];
        if (w) begin
          for (int k = 0; k < 8; k++) begin
            if (b[k]) begin
              model_mem[idx][k*8 +: 8] = d[k*8 +: 8];
            end
          end
        end
      end else if (a[31:28] == RegionRom && !w) begin
        exp_chk   = 1'b1;
        exp_rdata = RomPattern + 64'((a >> 3) % RomWords);
      end else begin
        exp_err = 1'b1;
        exp_chk = 1'b1;
      end
    end
  endtask

  // check the last response and drive the next request on one falling edge
  task automatic issue(input logic r, input logic w, input addr_t a, input strb_t b,
                       input data_t d);
    @(negedge clk);
    check_response();
    req   = r;
    we    = w;
    addr  = a;
    be    = b;
    wdata = d;
    predict(r, w, a, b, d);
  endtask

  task automatic set_ndmreset(input logic level);
    @(negedge clk);
    check_response();
    ndmreset = level;
    req      = 1'b0;
    if (level) begin
      sys_up = 1'b0;
    end
    predict(1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic report_test(input string name);
    issue(1'b0, 1'b0, '0, '0, '0);
    tests++;
    if (errors == test_errors) begin
      $display("test %-10s passed", name);
    end else begin
      failed++;
      $display("test %-10s failed with %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    #(TotalCycles * 2 * ClkPeriod);
    $display("timeout: the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(98));
    {ndmreset, req, we, addr, be, wdata} = '0;
    {jtag_sel, jtag_req, dtm_req} = 3'b111;
    {sys_up, exp_valid, exp_err, exp_chk, exp_rdata} = '0;
    {checks, errors, test_errors, tests, failed} = '0;
    fill_addr = '0;

    // ------------------------------------------------------------
    // debug window
    // ------------------------------------------------------------
    @(posedge rst_n);
    for (int i = 0; i < DbgDelay; i++) begin
      check_value("dbg_req_o in window", 64'(dbg_req), 64'(0));
      @(negedge clk);
    end
    // window is over and both sources are still high
    check_value("dbg_req_o after window", 64'(dbg_req), 64'(1));
    repeat (16) begin
      {jtag_sel, jtag_req, dtm_req} = 3'($urandom);
      @(negedge clk);
      check_value("dbg_req_o", 64'(dbg_req), 64'(jtag_sel ? jtag_req : dtm_req));
    end
    check_value("sys_rst_no", 64'(sys_rst_n), 64'(1));
    sys_up = 1'b1;
    report_test("debug");

    // ------------------------------------------------------------
    // sram fill, then random traffic
    // ------------------------------------------------------------
    for (int i = 0; i < SramWords; i++) begin
      fill_addr = {RegionDram, 28'(i * 8)};
      issue(1'b1, 1'b1, fill_addr, '1, {~fill_addr, fill_addr});
    end
    repeat (NumRandom) begin
      issue(1'b1, 1'($urandom), {RegionDram, 28'($urandom)}, 8'($urandom),
            {$urandom, $urandom});
    end
    report_test("sram");

    // rom reads, then writes that must bounce
    repeat (24) begin
      issue(1'b1, 1'b0, {RegionRom, 28'($urandom)}, '0, '0);
    end
    repeat (4) begin
      offset = 28'($urandom);
      issue(1'b1, 1'b1, {RegionRom, offset}, '1, {$urandom, $urandom});
      issue(1'b1, 1'b0, {RegionRom, offset}, '0, '0);
    end
    report_test("rom");

    // each unmapped access is followed by a read of the aliased sram word
    repeat (20) begin
      do begin
        region = 4'($urandom);
      end while (region == RegionRom || region == RegionDram);
      offset = 28'($urandom);
      issue(1'b1, 1'($urandom), {region, offset}, 8'($urandom), {$urandom, $urandom});
      issue(1'b1, 1'b0, {RegionDram, offset}, '0, '0);
    end
    report_test("unmapped");

    // ------------------------------------------------------------
    // ndmreset pulse
    // ------------------------------------------------------------
    {jtag_sel, jtag_req, dtm_req} = 3'b110;
    set_ndmreset(1'b1);
    for (int i = 0; i < 4; i++) begin
      issue(1'b1, 1'b1, {RegionDram, 28'(i * 8)}, '1, '0);
      check_value("sys_rst_no in ndmreset", 64'(sys_rst_n), 64'(0));
      check_value("dbg_req_o in ndmreset", 64'(dbg_req), 64'(1));
    end
    set_ndmreset(1'b0);
    // two edges through the synchronizer
    issue(1'b0, 1'b0, '0, '0, '0);
    check_value("sys_rst_no after one edge", 64'(sys_rst_n), 64'(0));
    issue(1'b0, 1'b0, '0, '0, '0);
    check_value("sys_rst_no after release", 64'(sys_rst_n), 64'(1));
    sys_up = 1'b1;
    for (int i = 0; i < 4; i++) begin
      issue(1'b1, 1'b0, {RegionDram, 28'(i * 8)}, '0, '0);
      check_value("dbg_req_o after ndmreset", 64'(dbg_req), 64'(1));
    end
    report_test("ndmreset");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== soc_harness.f ====
src/harness_cfg_pkg.sv
src/harness_bus_pkg.sv
src/mem_bus_if.sv
src/reset_sync.sv
src/debug_gate.sv
src/bus_demux.sv
src/boot_rom.sv
src/sram.sv
src/soc_harness.sv
sim/tb_clk_gen.sv
sim/soc_harness_checker.sv
sim/tb_soc_harness.sv

// ==== src/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom (
  input  logic     clk_i,
  mem_bus_if.slave bus
);
  import harness_bus_pkg::*;
  import harness_cfg_pkg::*;

  localparam int unsigned IdxWidth = (RomWords > 1) ? $clog2(RomWords) : 1;

  bus_addr_u           addr_u;
  logic [IdxWidth-1:0] word_idx;
  data_t               rom_mem [RomWords];
  data_t               rdata_q;
  logic                rvalid_q;

  // word index wraps around the rom size
  assign addr_u.raw = bus.addr;
  assign word_idx   = IdxWidth'((addr_u.raw >> ByteOffset) % RomWords);

  for (genvar i = 0; i < RomWords; i++) begin : gen_rom
    assign rom_mem[i] = rom_word(i);
  end

  always_ff @(posedge clk_i) begin
    rvalid_q <= bus.req;
    if (bus.req) begin
      rdata_q <= rom_mem[word_idx];
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rvalid = rvalid_q;

endmodule

// ==== src/bus_demux.sv ====
`timescale 1ns/1ps

module bus_demux (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  harness_bus_pkg::addr_t addr_i,
  input  harness_bus_pkg::strb_t be_i,
  input  harness_bus_pkg::data_t wdata_i,
  mem_bus_if.master              rom_bus,
  mem_bus_if.master              dram_bus,
  output logic                   rvalid_o,
  output logic                   err_o,
  output harness_bus_pkg::data_t rdata_o
);
  import harness_bus_pkg::*;
  import harness_cfg_pkg::*;

  bus_addr_u addr_u;
  logic      is_rom;
  logic      is_dram;
  logic      rom_hit;
  logic      dram_hit;
  logic      err_hit;
  logic      rom_sel_q;
  logic      dram_sel_q;
  logic      err_q;

  // ----------------------------------------------------------
  // address decode
  // ----------------------------------------------------------
  assign addr_u.raw = addr_i;
  assign is_rom     = (addr_u.field.region == RegionRom);
  assign is_dram    = (addr_u.field.region == RegionDram);

  // rom writes go to the error responder
  assign rom_hit  = req_i & is_rom & ~we_i;
  assign dram_hit = req_i & is_dram;
  assign err_hit  = req_i & ~rom_hit & ~dram_hit;

  // rom is read only
  assign rom_bus.req   = rom_hit;
  assign rom_bus.we    = 1'b0;
  assign rom_bus.addr  = addr_i;
  assign rom_bus.be    = '0;
  assign rom_bus.wdata = '0;

  assign dram_bus.req   = dram_hit;
  assign dram_bus.we    = we_i;
  assign dram_bus.addr  = addr_i;
  assign dram_bus.be    = be_i;
  assign dram_bus.wdata = wdata_i;

  // ----------------------------------------------------------
  // response side
  // ----------------------------------------------------------
  // remember which target owes the response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rom_sel_q  <= 1'b0;
      dram_sel_q <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      rom_sel_q  <= rom_hit;
      dram_sel_q <= dram_hit;
      err_q      <= err_hit;
    end
  end

  always_comb begin
    rvalid_o = err_q | (rom_sel_q & rom_bus.rvalid) | (dram_sel_q & dram_bus.rvalid);
    err_o    = err_q;
    // error responses return zero data
    if (rom_sel_q) begin
      rdata_o = rom_bus.rdata;
    end else if (dram_sel_q) begin
      rdata_o = dram_bus.rdata;
    end else begin
      rdata_o = '0;
    end
  end

endmodule

// ==== src/debug_gate.sv ====
`timescale 1ns/1ps

module debug_gate #(
  parameter int unsigned DebugDelay = harness_cfg_pkg::DefaultDebugDelay
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic jtag_sel_i,
  input  logic jtag_req_i,
  input  logic dtm_req_i,
  output logic dbg_req_o
);

  localparam int unsigned CntWidth = (DebugDelay > 0) ? $clog2(DebugDelay + 1) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] cnt_d;
  logic                hold;
  logic                dbg_req_ungated;

  // ----------------------------------------------------------
  // source select
  // ----------------------------------------------------------
  assign dbg_req_ungated = jtag_sel_i ? jtag_req_i : dtm_req_i;

  // ----------------------------------------------------------
  // delay window
  // ----------------------------------------------------------
  // lets the core run boot code before debug can interrupt it
  assign hold  = (cnt_q != '0);
  assign cnt_d = hold ? cnt_q - 1'b1 : cnt_q;

  // only power-on reset restarts the window
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DebugDelay);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign dbg_req_o = hold ? 1'b0 : dbg_req_ungated;

endmodule

// ==== src/harness_bus_pkg.sv ====
package harness_bus_pkg;

  // ----------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  // byte offset bits below the word index
  localparam int unsigned ByteOffset  = $clog2(StrbWidth);
  localparam int unsigned RegionWidth = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // raw view indexes the memories, field view feeds the decoder
  typedef union packed {
    addr_t raw;
    struct packed {
      logic [RegionWidth-1:0]           region;
      logic [AddrWidth-RegionWidth-1:0] offset;
    } field;
  } bus_addr_u;

endpackage

// ==== src/harness_cfg_pkg.sv ====
package harness_cfg_pkg;

  // ----------------------------------------------------------
  // address map
  // ----------------------------------------------------------
  // region nibble is the top four address bits
  localparam logic [3:0] RegionRom  = 4'h1;
  localparam logic [3:0] RegionDram = 4'h8;

  // ----------------------------------------------------------
  // memory sizes and timing defaults
  // ----------------------------------------------------------
  localparam int unsigned RomWords          = 16;
  localparam int unsigned DefaultSramWords  = 256;
  localparam int unsigned DefaultDebugDelay = 20;

  // boot rom word i holds the pattern plus i
  localparam logic [63:0] RomPattern = 64'h0000_0013_0000_0000;

  function automatic logic [63:0] rom_word(int unsigned idx);
    return RomPattern + 64'(idx % RomWords);
  endfunction

endpackage

// ==== src/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;
  import harness_bus_pkg::*;

  // request strobe and payload
  logic  req;
  logic  we;
  addr_t addr;
  strb_t be;
  data_t wdata;
  // response one cycle after req
  data_t rdata;
  logic  rvalid;

  modport master (
    output req, we, addr, be, wdata,
    input  rdata, rvalid
  );

  modport slave (
    input  req, we, addr, be, wdata,
    output rdata, rvalid
  );

endinterface

// ==== src/reset_sync.sv ====
`timescale 1ns/1ps

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // power-on reset or debug module reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // asserts at once, releases after two edges
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

endmodule

// ==== src/soc_harness.sv ====
`timescale 1ns/1ps

module soc_harness #(
  parameter int unsigned NumWords   = harness_cfg_pkg::DefaultSramWords,
  parameter int unsigned DebugDelay = harness_cfg_pkg::DefaultDebugDelay
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ndmreset_i,
  input  logic                   jtag_sel_i,
  input  logic                   jtag_req_i,
  input  logic                   dtm_req_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  harness_bus_pkg::addr_t addr_i,
  input  harness_bus_pkg::strb_t be_i,
  input  harness_bus_pkg::data_t wdata_i,
  output harness_bus_pkg::data_t rdata_o,
  output logic                   rvalid_o,
  output logic                   err_o,
  output logic                   dbg_req_o,
  output logic                   sys_rst_no
);

  mem_bus_if rom_bus ();
  mem_bus_if dram_bus ();

  // ----------------------------------------------------------
  // reset and debug
  // ----------------------------------------------------------
  reset_sync i_reset_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .rst_no     ( sys_rst_no )
  );

  // window runs off power-on reset only
  debug_gate #(
    .DebugDelay ( DebugDelay )
  ) i_debug_gate (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .jtag_sel_i ( jtag_sel_i ),
    .jtag_req_i ( jtag_req_i ),
    .dtm_req_i  ( dtm_req_i  ),
    .dbg_req_o  ( dbg_req_o  )
  );

  // ----------------------------------------------------------
  // memory bus
  // ----------------------------------------------------------
  bus_demux i_bus_demux (
    .clk_i    ( clk_i      ),
    .rst_ni   ( sys_rst_no ),
    .req_i    ( req_i      ),
    .we_i     ( we_i       ),
    .addr_i   ( addr_i     ),
    .be_i     ( be_i       ),
    .wdata_i  ( wdata_i    ),
    .rom_bus  ( rom_bus    ),
    .dram_bus ( dram_bus   ),
    .rvalid_o ( rvalid_o   ),
    .err_o    ( err_o      ),
    .rdata_o  ( rdata_o    )
  );

  boot_rom i_boot_rom (
    .clk_i ( clk_i   ),
    .bus   ( rom_bus )
  );

  sram #(
    .NumWords ( NumWords )
  ) i_sram (
    .clk_i  ( clk_i      ),
    .rst_ni ( sys_rst_no ),
    .bus    ( dram_bus   )
  );

endmodule

// ==== src/sram.sv ====
`timescale 1ns/1ps

module sram #(
  parameter int unsigned NumWords = harness_cfg_pkg::DefaultSramWords
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  mem_bus_if.slave bus
);
  import harness_bus_pkg::*;

  localparam int unsigned IdxWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

  bus_addr_u           addr_u;
  logic [IdxWidth-1:0] word_idx;
  data_t               mem_q [NumWords];
  data_t               rdata_q;
  logic                rvalid_q;

  assign addr_u.raw = bus.addr;
  assign word_idx   = IdxWidth'((addr_u.raw >> ByteOffset) % NumWords);

  // contents survive ndmreset, accesses only out of reset
  always_ff @(posedge clk_i) begin
    if (bus.req && rst_ni) begin
      // read returns the old word on a write
      rdata_q <= mem_q[word_idx];
      if (bus.we) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (bus.be[b]) begin
            mem_q[word_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rvalid = rvalid_q;

endmodule
